// ==== common/lsu_cfg.svh ====
/*
 * LSU configuration
 * data width, byte lane count and byte offset width of the load/store unit
 */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// one data word, also the address width
`define LSU_DATA_W 32
// byte lanes per word
`define LSU_BE_W 4
// byte offset inside a word
`define LSU_OFS_W 2

`endif

// ==== common/lsu_bus_pkg.sv ====
/*
 * LSU bus types
 * word, address and byte enable of the data memory port
 */
`default_nettype none

`include "lsu_cfg.svh"

package lsu_bus_pkg;

  // one data word on the memory port
  typedef logic [`LSU_DATA_W-1:0] word_t;

  // byte address into data memory
  typedef logic [`LSU_DATA_W-1:0] addr_t;

  // one enable per byte lane
  typedef logic [`LSU_BE_W-1:0] be_t;

endpackage

`default_nettype wire

// ==== common/lsu_op_pkg.sv ====
/*
 * LSU operation types
 * access size, byte offset and controller state seen from the core
 */
`default_nettype none

`include "lsu_cfg.svh"

package lsu_op_pkg;

  // 2'b11 is not named and decodes as byte
  typedef enum logic [1:0] {
    size_word = 2'b00,
    size_half = 2'b01,
    size_byte = 2'b10
  } size_e;

  typedef logic [`LSU_OFS_W-1:0] offset_t; // byte offset inside a word

  typedef enum logic [1:0] {
    st_idle,
    st_wait_rvalid,
    st_wait_rvalid_ex_stall, // granted during EX stall
    st_idle_ex_stall
  } lsu_state_e;

endpackage

`default_nettype wire

// ==== common/lsu_access_if.sv ====
/*
 * LSU access attributes
 * carries one access from request preparation to the load aligner
 */
`timescale 1ns/10ps
`default_nettype none

interface lsu_access_if;

  lsu_op_pkg::offset_t offset;       // address byte offset
  lsu_op_pkg::size_e   size;         // word, half or byte
  logic                sign_ext;     // sign extend the load result
  logic                we;           // store when high
  logic                split_access; // either part of a misaligned access

  // request side
  modport source (output offset, size, sign_ext, we, split_access);

  // load alignment side
  modport sink (input offset, size, sign_ext, we, split_access);

endinterface

`default_nettype wire

// ==== align/lsu_req_prep.sv ====
/*
 * LSU request preparation
 * address generation, misalignment detection, byte enables
 * and store data rotation, all combinational from EX
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_req_prep
(
  input  wire logic                data_req_i,
  input  wire logic                data_we_i,
  input  wire lsu_op_pkg::size_e   data_size_i,
  input  wire lsu_bus_pkg::word_t  data_wdata_i,
  input  wire lsu_op_pkg::offset_t data_reg_offset_i, // byte position in the register
  input  wire logic                data_sign_ext_i,
  input  wire lsu_bus_pkg::addr_t  operand_a_i,
  input  wire lsu_bus_pkg::addr_t  operand_b_i,
  input  wire logic                addr_useincr_i,    // a + b when high
  input  wire logic                data_misaligned_i, // second part of a split access
  output lsu_bus_pkg::addr_t       data_addr_o,
  output logic                     data_we_o,
  output lsu_bus_pkg::be_t         data_be_o,
  output lsu_bus_pkg::word_t       data_wdata_o,
  output logic                     data_misaligned_o,
  lsu_access_if.source             access_o
);

  lsu_op_pkg::offset_t addr_ofs;  // byte offset of the address
  lsu_op_pkg::offset_t rot_ofs;   // store data rotation in bytes

  assign data_addr_o = addr_useincr_i ? operand_a_i + operand_b_i : operand_a_i;
  assign addr_ofs    = data_addr_o[1:0];
  assign data_we_o   = data_we_i;

  // first part only, and only with a request
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i)
    begin
      case (data_size_i)
        lsu_op_pkg::size_word: data_misaligned_o = (addr_ofs != 2'd0);
        lsu_op_pkg::size_half: data_misaligned_o = (addr_ofs == 2'd3);
        default:               data_misaligned_o = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // byte enables
  always_comb
  begin
    case (data_size_i)
      lsu_op_pkg::size_word:
        // second part covers the lanes left over from the first
        data_be_o = data_misaligned_i ? ~(4'b1111 << addr_ofs) : (4'b1111 << addr_ofs);
      lsu_op_pkg::size_half:
        data_be_o = data_misaligned_i ? 4'b0001 : 4'(4'b0011 << addr_ofs);
      default:
        data_be_o = 4'b0001 << addr_ofs;
    endcase
  end

  // rotate register bytes onto their memory lanes
  assign rot_ofs = addr_ofs - data_reg_offset_i;

  always_comb
  begin
    case (rot_ofs)
      2'd0: data_wdata_o = data_wdata_i;
      2'd1: data_wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2: data_wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      2'd3: data_wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};
      default: data_wdata_o = data_wdata_i;
    endcase
  end

  // attributes for the load aligner
  assign access_o.offset       = addr_ofs;
  assign access_o.size         = data_size_i;
  assign access_o.sign_ext     = data_sign_ext_i;
  assign access_o.we           = data_we_i;
  assign access_o.split_access = data_misaligned_i | data_misaligned_o;

endmodule

`default_nettype wire

// ==== align/lsu_load_align.sv ====
/*
 * LSU load aligner
 * keeps the granted access attributes, then aligns, assembles
 * and extends the returned load data
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_load_align
(
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               data_gnt_i,
  input  wire logic               data_rvalid_i,
  input  wire lsu_bus_pkg::word_t data_rdata_i,
  lsu_access_if.sink              access_i,
  output lsu_bus_pkg::word_t      data_rdata_o
);

  lsu_op_pkg::offset_t offset_q;   // offset of the outstanding access
  lsu_op_pkg::size_e   size_q;
  logic                sign_ext_q;
  logic                we_q;
  lsu_bus_pkg::word_t  rdata_q;    // first part word or last result

  logic [15:0]         half_sel;
  logic [7:0]          byte_sel;
  lsu_bus_pkg::word_t  rdata_w;
  lsu_bus_pkg::word_t  rdata_ext;  // final extended result

  // attributes travel with the grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      offset_q   <= '0;
      size_q     <= lsu_op_pkg::size_word;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      offset_q   <= access_i.offset;
      size_q     <= access_i.size;
      sign_ext_q <= access_i.sign_ext;
      we_q       <= access_i.we;
    end
  end

  //////////////////////////////////////////////////
  // lane selection and assembly
  always_comb
  begin
    case (offset_q)
      2'd0: rdata_w = data_rdata_i;
      2'd1: rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};  // upper part from new word
      2'd2: rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = data_rdata_i;
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'd0: half_sel = data_rdata_i[15:0];
      2'd1: half_sel = data_rdata_i[23:8];
      2'd2: half_sel = data_rdata_i[31:16];
      2'd3: half_sel = {data_rdata_i[7:0], rdata_q[31:24]}; // spans two words
      default: half_sel = data_rdata_i[15:0];
    endcase
  end

  assign byte_sel = data_rdata_i[{offset_q, 3'b000} +: 8];

  always_comb
  begin
    case (size_q)
      lsu_op_pkg::size_word: rdata_ext = rdata_w;
      lsu_op_pkg::size_half: rdata_ext = {{16{sign_ext_q & half_sel[15]}}, half_sel};
      default:               rdata_ext = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  // raw word for a first part, final value otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
      rdata_q <= access_i.split_access ? data_rdata_i : rdata_ext;
  end

  assign data_rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

  // a half store at offset 3 only completes as part of a split
  a_half_store_split: assert property (@(posedge clk) disable iff (!rst_n)
    (data_rvalid_i && we_q && size_q == lsu_op_pkg::size_half && offset_q == 2'd3)
    |-> access_i.split_access);

endmodule

`default_nettype wire

// ==== hw/lsu_ctrl_fsm.sv ====
/*
 * LSU controller
 * issues memory requests, waits for grant and rvalid and
 * follows EX stalls, drives the EX and WB ready signals
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl_fsm
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic data_req_i,    // request from EX
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  input  wire logic ex_valid_i,    // low while EX is stalled
  output logic      data_req_o,
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o
);

  lsu_op_pkg::lsu_state_e state_q, state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_op_pkg::st_idle;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // next state and outputs
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      lsu_op_pkg::st_idle:
      begin
        data_req_o = data_req_i;
        if (data_req_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // held until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? lsu_op_pkg::st_wait_rvalid
                                 : lsu_op_pkg::st_wait_rvalid_ex_stall;
        end
      end

      lsu_op_pkg::st_wait_rvalid:
      begin
        lsu_ready_wb_o = data_rvalid_i; // WB waits on the response
        if (data_rvalid_i)
        begin
          data_req_o = data_req_i;      // back-to-back request
          if (data_req_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (!data_gnt_i)
              state_d = lsu_op_pkg::st_idle;
            else if (!ex_valid_i)
              state_d = lsu_op_pkg::st_wait_rvalid_ex_stall;
          end
          else
            state_d = lsu_op_pkg::st_idle;
        end
      end

      // no new request here, EX still holds the old one
      lsu_op_pkg::st_wait_rvalid_ex_stall:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? lsu_op_pkg::st_idle : lsu_op_pkg::st_idle_ex_stall;
        else if (ex_valid_i)
          state_d = lsu_op_pkg::st_wait_rvalid; // stall gone, keep waiting
      end

      lsu_op_pkg::st_idle_ex_stall:
      begin
        if (ex_valid_i)
          state_d = lsu_op_pkg::st_idle;
      end

      default: state_d = lsu_op_pkg::st_idle;
    endcase
  end

  //////////////////////////////////////////////////
  // handshake checks

  // a grant while waiting needs the previous rvalid first
  a_gnt_after_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_op_pkg::st_wait_rvalid && data_gnt_i) |-> data_rvalid_i);

  // nothing outstanding in idle
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_op_pkg::st_idle) |-> !data_rvalid_i);

  // a grant under EX stall keeps new requests off while the stall lasts
  a_no_req_ex_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (((data_req_o && data_gnt_i) || state_q == lsu_op_pkg::st_wait_rvalid_ex_stall)
      && !ex_valid_i) |=> !data_req_o);

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
/*
 * Load/store unit top
 * address and store data preparation, load alignment and the
 * request/stall controller for a req/gnt/rvalid data memory port
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_top
(
  input  wire logic                clk,
  input  wire logic                rst_n,

  // data memory port
  output logic                     data_req_o,
  input  wire logic                data_gnt_i,
  input  wire logic                data_rvalid_i,
  output lsu_bus_pkg::addr_t       data_addr_o,
  output logic                     data_we_o,
  output lsu_bus_pkg::be_t         data_be_o,
  output lsu_bus_pkg::word_t       data_wdata_o,
  input  wire lsu_bus_pkg::word_t  data_rdata_i,

  // from EX stage
  input  wire logic                data_req_i,
  input  wire logic                data_we_i,
  input  wire lsu_op_pkg::size_e   data_size_i,
  input  wire lsu_bus_pkg::word_t  data_wdata_i,
  input  wire lsu_op_pkg::offset_t data_reg_offset_i,
  input  wire logic                data_sign_ext_i,
  input  wire lsu_bus_pkg::addr_t  operand_a_i,
  input  wire lsu_bus_pkg::addr_t  operand_b_i,
  input  wire logic                addr_useincr_i,
  input  wire logic                data_misaligned_i, // second part in progress
  input  wire logic                ex_valid_i,

  // to pipeline
  output lsu_bus_pkg::word_t       data_rdata_o,
  output logic                     data_misaligned_o, // first part needs a second
  output logic                     lsu_ready_ex_o,
  output logic                     lsu_ready_wb_o
);

  lsu_access_if access_if ();  // attributes of the current access

  //////////////////////////////////////////////////
  // request side
  lsu_req_prep lsu_req_prep_i
  (
    .data_req_i        ( data_req_i        ),
    .data_we_i         ( data_we_i         ),
    .data_size_i       ( data_size_i       ),
    .data_wdata_i      ( data_wdata_i      ),
    .data_reg_offset_i ( data_reg_offset_i ),
    .data_sign_ext_i   ( data_sign_ext_i   ),
    .operand_a_i       ( operand_a_i       ),
    .operand_b_i       ( operand_b_i       ),
    .addr_useincr_i    ( addr_useincr_i    ),
    .data_misaligned_i ( data_misaligned_i ),
    .data_addr_o       ( data_addr_o       ),
    .data_we_o         ( data_we_o         ),
    .data_be_o         ( data_be_o         ),
    .data_wdata_o      ( data_wdata_o      ),
    .data_misaligned_o ( data_misaligned_o ),
    .access_o          ( access_if.source  )
  );

  //////////////////////////////////////////////////
  // response side
  lsu_load_align lsu_load_align_i
  (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .data_gnt_i    ( data_gnt_i     ),
    .data_rvalid_i ( data_rvalid_i  ),
    .data_rdata_i  ( data_rdata_i   ),
    .access_i      ( access_if.sink ),
    .data_rdata_o  ( data_rdata_o   )
  );

  lsu_ctrl_fsm lsu_ctrl_fsm_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .data_req_i     ( data_req_i     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .ex_valid_i     ( ex_valid_i     ),
    .data_req_o     ( data_req_o     ),
    .lsu_ready_ex_o ( lsu_ready_ex_o ),
    .lsu_ready_wb_o ( lsu_ready_wb_o )
  );

endmodule

`default_nettype wire

// ==== verification/lsu_tb.sv ====
/*
 * LSU testbench
 * golden file driven accesses against a random latency memory
 * responder with random EX stalls
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

  localparam int num_acc  = 26;  // accesses in the golden file
  localparam int num_fld  = 15;  // fields per access
  localparam int max_wait = 40;  // cycles per wait loop

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                data_gnt_i    = 1'b0;
  logic                data_rvalid_i = 1'b0;
  lsu_bus_pkg::word_t  data_rdata_i  = '0;
  logic                ex_valid_i    = 1'b1;
  logic                data_req_i;
  logic                data_we_i;
  lsu_op_pkg::size_e   data_size_i;
  lsu_bus_pkg::word_t  data_wdata_i;
  lsu_op_pkg::offset_t data_reg_offset_i;
  logic                data_sign_ext_i;
  lsu_bus_pkg::addr_t  operand_a_i;
  lsu_bus_pkg::addr_t  operand_b_i;
  logic                addr_useincr_i;
  logic                data_misaligned_i;

  // DUT outputs
  logic                data_req_o;
  lsu_bus_pkg::addr_t  data_addr_o;
  logic                data_we_o;
  lsu_bus_pkg::be_t    data_be_o;
  lsu_bus_pkg::word_t  data_wdata_o;
  lsu_bus_pkg::word_t  data_rdata_o;
  logic                data_misaligned_o;
  logic                lsu_ready_ex_o;
  logic                lsu_ready_wb_o;

  logic [31:0]         golden [0:num_acc*num_fld-1];
  lsu_bus_pkg::word_t  mem_word = '0;  // word for the next rvalid
  int                  seed = 93;
  int                  gnt_wait = 0;   // cycles left before the next grant
  int                  err_count = 0;
  int                  timeout_count = 0;
  logic                stall_seen = 1'b0; // granted while EX stalled

  // expected request attributes of the current part
  lsu_bus_pkg::addr_t  exp_addr;
  lsu_bus_pkg::be_t    exp_be;
  lsu_bus_pkg::word_t  exp_wdata;
  logic                exp_mis;
  logic                exp_we;

  lsu_top lsu_top_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // memory responder and EX stall source
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      ex_valid_i    <= 1'b1;
    end
    else
    begin
      data_rvalid_i <= data_gnt_i;           // one rvalid per grant, a cycle later
      if (data_gnt_i)
      begin
        data_rdata_i <= mem_word;
        data_gnt_i   <= 1'b0;
      end
      else if (data_req_o)
      begin
        if (gnt_wait == 0)
        begin
          data_gnt_i <= 1'b1;
          gnt_wait = $random(seed) & 3;      // 0..3 extra cycles next time
        end
        else
          gnt_wait = gnt_wait - 1;
      end
      ex_valid_i <= ($random(seed) & 3) != 0; // stall about one cycle in four
    end
  end

  // no new request while EX is stalled after a grant
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (stall_seen && !ex_valid_i)
        check_bit("data_req_o", data_req_o, 1'b0);
      if (ex_valid_i)
        stall_seen = 1'b0;
      if (data_gnt_i && data_req_o && !ex_valid_i)
        stall_seen = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input lsu_bus_pkg::word_t got,
                            input lsu_bus_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_be(input string name, input lsu_bus_pkg::be_t got,
                          input lsu_bus_pkg::be_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic abort_run(input string what);
    timeout_count++;
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
    $display("Something failed");
    $finish;
  endtask

  task automatic check_attrs();
    check_word("data_addr_o", data_addr_o, exp_addr);
    check_be("data_be_o", data_be_o, exp_be);
    check_word("data_wdata_o", data_wdata_o, exp_wdata);
    check_bit("data_misaligned_o", data_misaligned_o, exp_mis);
    check_bit("data_we_o", data_we_o, exp_we);
  endtask

  // request attributes must hold until the grant
  task automatic wait_grant(input string what);
    int n;
    for (n = 0; n < max_wait; n++)
    begin
      @(negedge clk);
      check_attrs();
      if (data_gnt_i && data_req_o)
        break;
      if (data_req_o)
        check_bit("lsu_ready_ex_o", lsu_ready_ex_o, 1'b0); // back-pressure
    end
    if (n == max_wait)
      abort_run(what);
  endtask

  task automatic wait_rvalid(input string what);
    int n;
    for (n = 0; n < max_wait; n++)
    begin
      @(negedge clk);
      if (data_rvalid_i)
        break;
    end
    if (n == max_wait)
      abort_run(what);
  endtask

  //////////////////////////////////////////////////
  // one access, split in two parts when misaligned
  task automatic run_access(input int idx);
    logic [31:0]         fld [0:num_fld-1];
    lsu_bus_pkg::addr_t  addr;
    lsu_op_pkg::offset_t ofs;
    logic                split;
    for (int i = 0; i < num_fld; i++)
      fld[i] = golden[idx*num_fld + i];
    addr  = fld[5][0] ? fld[3] + fld[4] : fld[3];
    ofs   = addr[1:0];
    split = (fld[1][1:0] == 2'd0 && ofs != 2'd0) || (fld[1][1:0] == 2'd1 && ofs == 2'd3);
    exp_addr  = addr;
    exp_be    = fld[10][3:0];
    exp_wdata = fld[11];
    exp_mis   = split;
    exp_we    = fld[0][0];

    @(posedge clk);
    data_req_i        <= 1'b1;
    data_we_i         <= fld[0][0];
    data_size_i       <= lsu_op_pkg::size_e'(fld[1][1:0]);
    data_sign_ext_i   <= fld[2][0];
    operand_a_i       <= fld[3];
    operand_b_i       <= fld[4];
    addr_useincr_i    <= fld[5][0];
    data_wdata_i      <= fld[6];
    data_reg_offset_i <= fld[7][1:0];
    data_misaligned_i <= 1'b0;
    mem_word          <= fld[8];
    wait_grant("first part grant");

    @(posedge clk);
    if (split)
    begin
      // second part at the next word, same byte offset
      exp_addr  = addr + 32'd4;
      exp_be    = fld[12][3:0];
      exp_wdata = fld[13];
      exp_mis   = 1'b0;
      operand_a_i       <= addr + 32'd4;
      operand_b_i       <= '0;
      addr_useincr_i    <= 1'b0;
      data_misaligned_i <= 1'b1;
      mem_word          <= fld[9];
    end
    else
      data_req_i <= 1'b0;
    wait_rvalid("first part rvalid");

    if (split)
    begin
      wait_grant("second part grant");
      @(posedge clk);
      data_req_i        <= 1'b0;
      data_misaligned_i <= 1'b0;
      wait_rvalid("second part rvalid");
    end
    if (!fld[0][0])
      check_word("data_rdata_o", data_rdata_o, fld[14]);
  endtask

  initial
  begin
    $readmemh("verification/lsu_golden.txt", golden);
    data_req_i        = 1'b0;
    data_we_i         = 1'b0;
    data_size_i       = lsu_op_pkg::size_word;
    data_wdata_i      = '0;
    data_reg_offset_i = '0;
    data_sign_ext_i   = 1'b0;
    operand_a_i       = '0;
    operand_b_i       = '0;
    addr_useincr_i    = 1'b0;
    data_misaligned_i = 1'b0;
    rst_n             = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_bit("data_req_o", data_req_o, 1'b0);
    check_bit("lsu_ready_ex_o", lsu_ready_ex_o, 1'b1);
    check_bit("lsu_ready_wb_o", lsu_ready_wb_o, 1'b1);
    check_word("data_rdata_o", data_rdata_o, '0);

    for (int i = 0; i < num_acc; i++)
      run_access(i);

    $display("errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/lsu_golden.txt ====
// we size sign opa opb incr wdata regofs mem0 mem1 be0 wdata0 be1 wdata1 result
// size: 0 word, 1 half, 2 byte; all values hex
1 0 0 00001000 00000010 1 11223344 0 0 0 f 11223344 0 0 0
1 1 0 00001000 00000002 1 0000abcd 0 0 0 c abcd0000 0 0 0
1 1 0 00001001 00000000 0 00005566 0 0 0 6 00556600 0 0 0
1 1 0 00002000 00000004 1 1234beef 0 0 0 3 1234beef 0 0 0
1 2 0 00003000 00000000 1 000000aa 0 0 0 1 000000aa 0 0 0
1 2 0 00003000 00000001 1 000000bb 0 0 0 2 0000bb00 0 0 0
1 2 0 00003002 00000000 0 000000cc 0 0 0 4 00cc0000 0 0 0
1 2 0 00003000 00000003 1 000000dd 0 0 0 8 dd000000 0 0 0
1 2 0 00003000 00000003 1 0000ee00 1 0 0 8 ee000000 0 0 0
1 2 0 00003000 00000000 1 00ff0000 2 0 0 1 000000ff 0 0 0
0 0 0 00004000 00000000 1 0 0 deadbeef 0 f 0 0 0 deadbeef
0 2 0 00004000 00000000 1 0 0 80c1a2f3 0 1 0 0 0 000000f3
0 2 1 00004000 00000001 1 0 0 80c1a2f3 0 2 0 0 0 ffffffa2
0 2 0 00004000 00000002 1 0 0 80c1a2f3 0 4 0 0 0 000000c1
0 2 1 00004003 00000000 0 0 0 80c1a2f3 0 8 0 0 0 ffffff80
0 2 1 00004000 00000002 1 0 0 12345678 0 4 0 0 0 00000034
0 1 1 00004000 00000000 1 0 0 1234f00d 0 3 0 0 0 fffff00d
0 1 0 00004000 00000001 1 0 0 00abcd00 0 6 0 0 0 0000abcd
0 1 1 00004000 00000002 1 0 0 7ffe0001 0 c 0 0 0 00007ffe
0 1 1 00004002 00000000 0 0 0 8001aaaa 0 c 0 0 0 ffff8001
0 0 0 00005000 00000001 1 0 0 44332211 88776655 e 0 1 0 55443322
0 0 0 00005000 00000002 1 0 0 44332211 88776655 c 0 3 0 66554433
0 0 0 00005000 00000003 1 0 0 44332211 88776655 8 0 7 0 77665544
0 1 1 00006000 00000003 1 0 0 3c000000 000000f2 8 0 1 0 fffff23c
0 1 0 00006003 00000000 0 0 0 99000000 ffffff81 8 0 1 0 00008199
0 0 0 00007001 00000000 0 0 0 ccbbaa00 000000dd e 0 1 0 ddccbbaa

// ==== flist.f ====
+incdir+common
common/lsu_bus_pkg.sv
common/lsu_op_pkg.sv
common/lsu_access_if.sv
align/lsu_req_prep.sv
align/lsu_load_align.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_top.sv
verification/lsu_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module lsu_tb -f flist.f -o lsu_sim
	./obj_dir/lsu_sim | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
